// File: sources.f
+incdir+tb
logic/pkt_pkg.sv
logic/pkt_skid_buf.sv
logic/pkt_len_check.sv
logic/pkt_meta_stamp.sv
logic/pkt_stamp_path.sv
tb/pkt_stamp_path_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the stamping path testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pkt_stamp_path_tb \
    -f sources.f \
    -o sim_pkt_stamp_path

./obj_dir/sim_pkt_stamp_path 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished, see sim.log"

// File: tb/pkt_tb_util.svh
// LFSR and reference model state
logic [31:0]                  lfsr_state = 32'h2e59_fc19;
logic                         ref_sop = 1'b1;
logic [pkt_pkg::META_WID-1:0] ref_meta = '0;
int                           ref_len = 0;

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_bit()};
    end
    return v;
endfunction

function automatic pkt_pkg::in_beat_t pack_in_beat(
    input logic [pkt_pkg::DATA_BYTES*8-1:0] data,
    input logic                             eop,
    input logic [pkt_pkg::MTY_WID-1:0]      mty,
    input logic                             err,
    input logic [pkt_pkg::META_WID-1:0]     meta
);
    pkt_pkg::in_beat_t b;
    b.data = data;
    b.eop  = eop;
    b.mty  = mty;
    b.err  = err;
    b.meta = meta;
    return b;
endfunction

// Expected output for one accepted input beat, in input order
function automatic pkt_pkg::out_beat_t model_beat(input pkt_pkg::in_beat_t b);
    pkt_pkg::out_beat_t o;
    int                 beat_len;
    if (ref_sop) begin
        ref_meta = b.meta;
    end
    beat_len = b.eop ? pkt_pkg::DATA_BYTES - int'(b.mty) : pkt_pkg::DATA_BYTES;
    ref_len  = ref_len + beat_len;
    o.data = b.data;
    o.eop  = b.eop;
    o.mty  = b.mty;
    o.meta = ref_meta;
    o.err  = b.err || (b.eop && (ref_len < pkt_pkg::MIN_PKT_BYTES ||
                                 ref_len > pkt_pkg::MAX_PKT_BYTES));
    if (b.eop) begin
        ref_len = 0;
    end
    ref_sop = b.eop;
    return o;
endfunction

// File: tb/pkt_stamp_path_tb.sv
`timescale 1ns/1ps

module pkt_stamp_path_tb;

    localparam int CLK_PERIOD = 8;
    localparam int WAIT_LIMIT = 200;
    localparam int RDY_HIGH   = 0;
    localparam int RDY_RANDOM = 1;
    localparam int RDY_LOW    = 2;

    logic                             clk;
    logic                             srst;
    logic                             in_vld;
    logic                             in_rdy;
    logic [pkt_pkg::DATA_BYTES*8-1:0] in_data;
    logic                             in_eop;
    logic [pkt_pkg::MTY_WID-1:0]      in_mty;
    logic                             in_err;
    logic [pkt_pkg::META_WID-1:0]     in_meta;
    logic                             out_vld;
    logic                             out_rdy;
    logic [pkt_pkg::DATA_BYTES*8-1:0] out_data;
    logic                             out_eop;
    logic [pkt_pkg::MTY_WID-1:0]      out_mty;
    logic                             out_err;
    logic [pkt_pkg::META_WID-1:0]     out_meta;

    // Expected beats and the cycle each entered the DUT
    pkt_pkg::out_beat_t exp_q[$];
    int                 in_cyc_q[$];

    int cyc = 0;
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_clean = 0;
    int rdy_mode = RDY_HIGH;
    bit check_latency = 1'b0;
    int out_count = 0;
    int first_out_cyc = 0;
    int last_out_cyc = 0;
    bit saw_rdy_low = 1'b0;

    `include "pkt_tb_util.svh"

    pkt_stamp_path dut (
        .clk      (clk),
        .srst     (srst),
        .in_vld   (in_vld),
        .in_rdy   (in_rdy),
        .in_data  (in_data),
        .in_eop   (in_eop),
        .in_mty   (in_mty),
        .in_err   (in_err),
        .in_meta  (in_meta),
        .out_vld  (out_vld),
        .out_rdy  (out_rdy),
        .out_data (out_data),
        .out_eop  (out_eop),
        .out_mty  (out_mty),
        .out_err  (out_err),
        .out_meta (out_meta)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Sink ready pattern
    initial begin
        out_rdy = 1'b1;
        forever begin
            @(negedge clk);
            case (rdy_mode)
                RDY_RANDOM: out_rdy = (rand_bits(2) != 32'd0);
                RDY_LOW:    out_rdy = 1'b0;
                default:    out_rdy = 1'b1;
            endcase
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, exp, act);
        errors++;
    endtask

    task automatic check_output();
        pkt_pkg::out_beat_t exp;
        int                 in_cyc;
        assert (exp_q.size() > 0) else begin
            $display("output beat at %0t arrived with no beat outstanding", $time);
            errors++;
        end
        if (exp_q.size() > 0) begin
            exp    = exp_q.pop_front();
            in_cyc = in_cyc_q.pop_front();
            assert (out_data === exp.data)
                else report_mismatch("out_data", 64'(exp.data), 64'(out_data));
            assert (out_eop === exp.eop)
                else report_mismatch("out_eop", 64'(exp.eop), 64'(out_eop));
            assert (out_mty === exp.mty)
                else report_mismatch("out_mty", 64'(exp.mty), 64'(out_mty));
            assert (out_err === exp.err)
                else report_mismatch("out_err", 64'(exp.err), 64'(out_err));
            assert (out_meta === exp.meta)
                else report_mismatch("out_meta", 64'(exp.meta), 64'(out_meta));
            if (check_latency) begin
                assert (cyc - in_cyc == 2)
                    else report_mismatch("latency", 64'd2, 64'(cyc - in_cyc));
            end
            if (out_count == 0) begin
                first_out_cyc = cyc;
            end
            last_out_cyc = cyc;
            out_count++;
        end
    endtask

    // Output scoreboard
    initial begin
        forever begin
            @(posedge clk);
            if (out_vld === 1'b1 && out_rdy === 1'b1) begin
                check_output();
            end
        end
    end

    task automatic end_run(input bit aborted);
        $display("summary: %0d run, %0d clean, %0d check errors",
                 tests_run, tests_clean, errors);
        if (errors == 0 && !aborted) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            tests_clean++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    task automatic set_mode(input int mode, input bit latency);
        @(negedge clk);
        #1;
        rdy_mode      = mode;
        check_latency = latency;
    endtask

    task automatic wait_accept();
        int waited;
        waited = 0;
        @(posedge clk);
        while (in_rdy !== 1'b1) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout at %0t: input beat never accepted", $time);
                end_run(1'b1);
            end
            @(posedge clk);
        end
    endtask

    // Random fields are drawn before each falling edge wait
    task automatic send_packet(input int len, input bit gaps, input bit errs);
        pkt_pkg::in_beat_t           beat;
        logic [pkt_pkg::MTY_WID-1:0] mty;
        logic                        eop;
        bit                          gap;
        int                          nbeats;
        int                          b;
        nbeats = (len + pkt_pkg::DATA_BYTES - 1) / pkt_pkg::DATA_BYTES;
        for (b = 0; b < nbeats; b++) begin
            eop  = (b == nbeats - 1);
            mty  = eop ? pkt_pkg::MTY_WID'(nbeats * pkt_pkg::DATA_BYTES - len) : '0;
            beat = pack_in_beat(rand_bits(32), eop, mty,
                                errs && (rand_bits(3) == 32'd0), 8'(rand_bits(8)));
            gap  = gaps && (rand_bits(2) == 32'd0);
            if (gap) begin
                @(negedge clk);
                in_vld = 1'b0;
            end
            @(negedge clk);
            in_vld  = 1'b1;
            in_data = beat.data;
            in_eop  = beat.eop;
            in_mty  = beat.mty;
            in_err  = beat.err;
            in_meta = beat.meta;
            wait_accept();
            exp_q.push_back(model_beat(beat));
            in_cyc_q.push_back(cyc);
        end
    endtask

    task automatic idle_input();
        @(negedge clk);
        in_vld = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk);
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout at %0t: %0d beats never left the DUT", $time, exp_q.size());
                end_run(1'b1);
            end
            @(negedge clk);
        end
    endtask

    initial begin
        srst    = 1'b1;
        in_vld  = 1'b0;
        in_data = '0;
        in_eop  = 1'b0;
        in_mty  = '0;
        in_err  = 1'b0;
        in_meta = '0;

        repeat (4) begin
            @(negedge clk);
            assert (out_vld === 1'b0) else report_mismatch("out_vld", 64'd0, 64'(out_vld));
            assert (in_rdy === 1'b0) else report_mismatch("in_rdy", 64'd0, 64'(in_rdy));
        end
        srst = 1'b0;
        @(posedge clk);
        assert (out_vld === 1'b0) else report_mismatch("out_vld", 64'd0, 64'(out_vld));
        @(negedge clk);
        assert (out_vld === 1'b0) else report_mismatch("out_vld", 64'd0, 64'(out_vld));
        assert (in_rdy === 1'b1) else report_mismatch("in_rdy", 64'd1, 64'(in_rdy));
        send_packet(12, 1'b0, 1'b1);
        idle_input();
        wait_drain();
        finish_test("reset");

        // Lengths just inside and outside the legal range
        send_packet(5, 1'b0, 1'b0);
        send_packet(6, 1'b0, 1'b0);
        send_packet(64, 1'b0, 1'b0);
        send_packet(65, 1'b0, 1'b0);
        send_packet(1, 1'b0, 1'b0);
        idle_input();
        wait_drain();
        finish_test("bounds");

        set_mode(RDY_HIGH, 1'b1);
        out_count = 0;
        send_packet(32, 1'b0, 1'b1);
        idle_input();
        wait_drain();
        assert (last_out_cyc - first_out_cyc == 7)
            else report_mismatch("out_span", 64'd7, 64'(last_out_cyc - first_out_cyc));
        set_mode(RDY_HIGH, 1'b0);
        finish_test("latency");

        set_mode(RDY_LOW, 1'b0);
        saw_rdy_low = 1'b0;
        fork
            send_packet(40, 1'b0, 1'b1);
            begin
                @(negedge clk);
                repeat (10) begin
                    @(posedge clk);
                    if (in_rdy === 1'b0) begin
                        saw_rdy_low = 1'b1;
                    end
                end
                set_mode(RDY_HIGH, 1'b0);
            end
        join
        idle_input();
        wait_drain();
        assert (saw_rdy_low) else begin
            $display("in_rdy stayed high while out_rdy was held low");
            errors++;
        end
        finish_test("backpressure");

        set_mode(RDY_RANDOM, 1'b0);
        repeat (40) begin
            send_packet(1 + int'(rand_bits(7)) % 80, 1'b1, 1'b1);
        end
        idle_input();
        wait_drain();
        set_mode(RDY_HIGH, 1'b0);
        finish_test("random");

        end_run(1'b0);
    end

endmodule : pkt_stamp_path_tb

// File: logic/pkt_stamp_path.sv
`timescale 1ns/1ps

module pkt_stamp_path (
    input  logic                             clk,
    input  logic                             srst,

    input  logic                             in_vld,
    output logic                             in_rdy,
    input  logic [pkt_pkg::DATA_BYTES*8-1:0] in_data,
    input  logic                             in_eop,
    input  logic [pkt_pkg::MTY_WID-1:0]      in_mty,
    input  logic                             in_err,
    input  logic [pkt_pkg::META_WID-1:0]     in_meta,

    output logic                             out_vld,
    input  logic                             out_rdy,
    output logic [pkt_pkg::DATA_BYTES*8-1:0] out_data,
    output logic                             out_eop,
    output logic [pkt_pkg::MTY_WID-1:0]      out_mty,
    output logic                             out_err,
    output logic [pkt_pkg::META_WID-1:0]     out_meta
);

    pkt_pkg::in_beat_t  in_beat;
    pkt_pkg::in_beat_t  mid_beat;
    pkt_pkg::out_beat_t stamped_beat;
    pkt_pkg::out_beat_t out_beat;

    logic                         mid_vld;
    logic                         mid_rdy;
    logic                         mid_err;
    logic [pkt_pkg::META_WID-1:0] mid_meta;

    assign in_beat.data = in_data;
    assign in_beat.eop  = in_eop;
    assign in_beat.mty  = in_mty;
    assign in_beat.err  = in_err;
    assign in_beat.meta = in_meta;

    pkt_skid_buf #(
        .payload_t (pkt_pkg::in_beat_t)
    ) u_in_slice (
        .clk         (clk),
        .srst        (srst),
        .in_vld      (in_vld),
        .in_rdy      (in_rdy),
        .in_payload  (in_beat),
        .out_vld     (mid_vld),
        .out_rdy     (mid_rdy),
        .out_payload (mid_beat)
    );

    pkt_len_check u_len_check (
        .clk     (clk),
        .srst    (srst),
        .vld     (mid_vld),
        .rdy     (mid_rdy),
        .eop     (mid_beat.eop),
        .mty     (mid_beat.mty),
        .err_in  (mid_beat.err),
        .err_out (mid_err)
    );

    pkt_meta_stamp u_meta_stamp (
        .clk      (clk),
        .srst     (srst),
        .vld      (mid_vld),
        .rdy      (mid_rdy),
        .eop      (mid_beat.eop),
        .meta_in  (mid_beat.meta),
        .meta_out (mid_meta)
    );

    // Only err and meta are rewritten
    assign stamped_beat.data = mid_beat.data;
    assign stamped_beat.eop  = mid_beat.eop;
    assign stamped_beat.mty  = mid_beat.mty;
    assign stamped_beat.err  = mid_err;
    assign stamped_beat.meta = mid_meta;

    pkt_skid_buf #(
        .payload_t (pkt_pkg::out_beat_t)
    ) u_out_slice (
        .clk         (clk),
        .srst        (srst),
        .in_vld      (mid_vld),
        .in_rdy      (mid_rdy),
        .in_payload  (stamped_beat),
        .out_vld     (out_vld),
        .out_rdy     (out_rdy),
        .out_payload (out_beat)
    );

    assign out_data = out_beat.data;
    assign out_eop  = out_beat.eop;
    assign out_mty  = out_beat.mty;
    assign out_err  = out_beat.err;
    assign out_meta = out_beat.meta;

endmodule : pkt_stamp_path

// File: logic/pkt_meta_stamp.sv
`timescale 1ns/1ps

module pkt_meta_stamp (
    input  logic                         clk,
    input  logic                         srst,

    input  logic                         vld,
    input  logic                         rdy,
    input  logic                         eop,
    input  logic [pkt_pkg::META_WID-1:0] meta_in,
    output logic [pkt_pkg::META_WID-1:0] meta_out
);

    logic                         xfer;
    logic                         sop;
    logic [pkt_pkg::META_WID-1:0] meta_q;

    assign xfer = vld && rdy;

    // Start of packet follows each eop transfer
    always_ff @(posedge clk) begin
        if (srst) begin
            sop <= 1'b1;
        end else if (xfer) begin
            sop <= eop;
        end
    end

    // Capture metadata on first beat
    always_ff @(posedge clk) begin
        if (xfer && sop) begin
            meta_q <= meta_in;
        end
    end

    // First beat passes straight through, later beats reuse the held value
    assign meta_out = sop ? meta_in : meta_q;

endmodule : pkt_meta_stamp

// File: logic/pkt_len_check.sv
`timescale 1ns/1ps

module pkt_len_check (
    input  logic                       clk,
    input  logic                       srst,

    input  logic                       vld,
    input  logic                       rdy,
    input  logic                       eop,
    input  logic [pkt_pkg::MTY_WID-1:0] mty,
    input  logic                       err_in,
    output logic                       err_out
);

    typedef logic [pkt_pkg::LEN_WID:0] sum_t;

    logic                         xfer;
    logic [pkt_pkg::LEN_WID-1:0]  byte_cnt;
    logic [pkt_pkg::LEN_WID-1:0]  total;
    sum_t                         beat_bytes;
    sum_t                         sum;
    logic                         len_bad;

    assign xfer = vld && rdy;

    // Last beat carries DATA_BYTES minus the empty count
    assign beat_bytes = eop ? sum_t'(pkt_pkg::DATA_BYTES) - sum_t'(mty)
                            : sum_t'(pkt_pkg::DATA_BYTES);

    assign sum = sum_t'(byte_cnt) + beat_bytes;

    // Saturate at all ones
    assign total = sum[pkt_pkg::LEN_WID] ? '1 : sum[pkt_pkg::LEN_WID-1:0];

    assign len_bad = (total < pkt_pkg::LEN_WID'(pkt_pkg::MIN_PKT_BYTES)) ||
                     (total > pkt_pkg::LEN_WID'(pkt_pkg::MAX_PKT_BYTES));

    assign err_out = err_in || (eop && len_bad);

    always_ff @(posedge clk) begin
        if (srst) begin
            byte_cnt <= '0;
        end else if (xfer) begin
            if (eop) begin
                byte_cnt <= '0;
            end else begin
                byte_cnt <= total;
            end
        end
    end

    // Empty count only meaningful on last beat
    assert property (
        @(posedge clk) disable iff (srst)
        vld && !eop |-> mty == '0
    ) else $error("pkt_len_check: nonzero mty on non-eop beat");

endmodule : pkt_len_check

// File: logic/pkt_skid_buf.sv
`timescale 1ns/1ps

module pkt_skid_buf #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     srst,

    input  logic     in_vld,
    output logic     in_rdy,
    input  payload_t in_payload,

    output logic     out_vld,
    input  logic     out_rdy,
    output payload_t out_payload
);

    logic     in_xfer;
    logic     main_load;
    logic     spill_vld;
    logic     spill_vld_nxt;
    payload_t spill_payload;

    // in_rdy is registered, so it is low whenever the spill entry holds a beat
    assign in_xfer = in_vld && in_rdy;

    // Main entry can take a new beat when empty or draining
    assign main_load = !out_vld || out_rdy;

    always_comb begin
        spill_vld_nxt = spill_vld;
        if (main_load) begin
            spill_vld_nxt = 1'b0;
        end else if (in_xfer) begin
            spill_vld_nxt = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            out_vld   <= 1'b0;
            spill_vld <= 1'b0;
            in_rdy    <= 1'b0;
        end else begin
            spill_vld <= spill_vld_nxt;
            in_rdy    <= !spill_vld_nxt;
            if (main_load) begin
                out_vld <= spill_vld || in_xfer;
            end
        end
    end

    // Older beat in spill always goes out first
    always_ff @(posedge clk) begin
        if (main_load) begin
            out_payload <= spill_vld ? spill_payload : in_payload;
        end
        if (!main_load && in_xfer) begin
            spill_payload <= in_payload;
        end
    end

    // Output held while stalled
    assert property (
        @(posedge clk) disable iff (srst)
        out_vld && !out_rdy |=> $stable(out_payload)
    ) else $error("pkt_skid_buf: payload changed while stalled");

    // No accept with both entries occupied
    assert property (
        @(posedge clk) disable iff (srst)
        !(in_rdy && out_vld && spill_vld)
    ) else $error("pkt_skid_buf: in_rdy high while full");

endmodule : pkt_skid_buf

// File: logic/pkt_pkg.sv
package pkt_pkg;

    // Bus geometry
    localparam int DATA_BYTES = 4;
    localparam int MTY_WID    = 2;
    localparam int META_WID   = 8;

    // Legal packet length range, in bytes
    localparam int MIN_PKT_BYTES = 6;
    localparam int MAX_PKT_BYTES = 64;

    // Byte counter width, room for the max length plus one beat
    localparam int LEN_WID = 7;

    // Beat as it arrives on the input
    typedef struct packed {
        logic [DATA_BYTES*8-1:0] data;
        logic                    eop;
        logic [MTY_WID-1:0]      mty;
        logic                    err;
        logic [META_WID-1:0]     meta;
    } in_beat_t;

    // Beat after length check and metadata stamping
    typedef struct packed {
        logic [DATA_BYTES*8-1:0] data;
        logic                    eop;
        logic [MTY_WID-1:0]      mty;
        logic                    err;
        logic [META_WID-1:0]     meta;
    } out_beat_t;

endpackage : pkt_pkg
